/* verilog/conv_params.svh */
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// one signed feature or weight word
`define DATA_LEN 8
// signed accumulator and result width
`define ACC_LEN 24

`define READ_WORDS 9     // words per feature memory read
`define READS_PER_VEC 4  // reads packed into one vector
`define PHASES 8         // vectors summed into one row
`define ROWS 12          // rows per layer run
`define CHANNELS 4       // output channels

// vector buffer entries, also the initial credit count
`define FIFO_DEPTH 4

`define ADDR_LEN 9       // feature memory address

`endif

/* verilog/conv_pkg.sv */
`include "conv_params.svh"

package conv_pkg;

  // one feature memory read, nine signed words
  typedef struct packed {
    logic [`READ_WORDS-1:0][`DATA_LEN-1:0] w;
  } feat_word_t;

  // four reads plus the tags that place it in the layer
  typedef struct packed {
    logic [2:0] phase;
    logic [3:0] row;
    feat_word_t [`READS_PER_VEC-1:0] words;
  } feat_vec_t;

  // one nine-word weight entry for a channel/phase/beat
  typedef struct packed {
    logic [$clog2(`CHANNELS)-1:0] channel;
    logic [2:0] phase;
    logic [1:0] beat;
    feat_word_t data;
  } wt_wr_t;

  typedef struct packed {
    logic [3:0] row;
    logic [`CHANNELS-1:0][`ACC_LEN-1:0] acc;  // signed per channel
  } result_row_t;

endpackage

/* verilog/feature_fetch.sv */
`timescale 1ns/1ps
`include "conv_params.svh"

module feature_fetch
  import conv_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  output logic [`ADDR_LEN-1:0] feat_addr,
  input  feat_word_t           feat_data,
  output logic                 push,
  output feat_vec_t            vec_in,
  input  logic                 credit,
  output logic                 busy,
  input  logic                 row_done
);

  localparam int cred_len = $clog2(`FIFO_DEPTH) + 1;

  logic [cred_len-1:0] credit_cnt;
  logic [cred_len-1:0] inflight;  // vectors started but not pushed
  logic [3:0] row_cnt;
  logic [2:0] phase_cnt;
  logic [1:0] beat_cnt;
  logic [3:0] done_cnt;
  logic       fetching;
  logic       issue;
  logic       last_rd;
  logic       rd_vld;
  logic [1:0] rd_beat;
  logic [2:0] rd_phase;
  logic [3:0] rd_row;

  assign feat_addr = {row_cnt, phase_cnt, beat_cnt};  // row*32 + phase*4 + beat
  assign last_rd = (row_cnt == 4'(`ROWS - 1)) && (phase_cnt == 3'(`PHASES - 1)) &&
                   (beat_cnt == 2'(`READS_PER_VEC - 1));
  // a credit is reserved at beat 0, the rest of the vector follows
  assign issue = fetching && ((beat_cnt != 2'd0) || (credit_cnt > inflight));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      fetching   <= 1'b0;
      row_cnt    <= '0;
      phase_cnt  <= '0;
      beat_cnt   <= '0;
      done_cnt   <= '0;
      credit_cnt <= cred_len'(`FIFO_DEPTH);
      inflight   <= '0;
      rd_vld     <= 1'b0;
      push       <= 1'b0;
    end else begin
      rd_vld <= issue;
      push   <= rd_vld && (rd_beat == 2'(`READS_PER_VEC - 1));  // last beat captured
      if (start && !busy) begin
        busy      <= 1'b1;
        fetching  <= 1'b1;
        row_cnt   <= '0;
        phase_cnt <= '0;
        beat_cnt  <= '0;
        done_cnt  <= '0;
      end else begin
        if (issue) begin
          if (last_rd)
            fetching <= 1'b0;
          if (beat_cnt == 2'(`READS_PER_VEC - 1)) begin
            beat_cnt <= '0;
            if (phase_cnt == 3'(`PHASES - 1)) begin
              phase_cnt <= '0;
              row_cnt   <= row_cnt + 4'd1;
            end else begin
              phase_cnt <= phase_cnt + 3'd1;
            end
          end else begin
            beat_cnt <= beat_cnt + 2'd1;
          end
        end
        if (row_done) begin
          if (done_cnt == 4'(`ROWS - 1)) begin
            busy     <= 1'b0;
            done_cnt <= '0;
          end else begin
            done_cnt <= done_cnt + 4'd1;
          end
        end
      end
      case ({push, credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      case ({issue && (beat_cnt == 2'd0), push})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
    end
  end

  // read tags follow the one-cycle memory latency
  always_ff @(posedge clk) begin
    if (issue) begin
      rd_beat  <= beat_cnt;
      rd_phase <= phase_cnt;
      rd_row   <= row_cnt;
    end
    if (rd_vld) begin
      vec_in.words[rd_beat] <= feat_data;
      vec_in.phase          <= rd_phase;
      vec_in.row            <= rd_row;
    end
  end

  a_push_credit: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (credit_cnt != '0));

  a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= cred_len'(`FIFO_DEPTH));

endmodule

/* verilog/vector_fifo.sv */
`timescale 1ns/1ps
`include "conv_params.svh"

module vector_fifo
  import conv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      push,
  input  feat_vec_t vec_in,
  input  logic      pop,
  output logic      vec_valid,
  output feat_vec_t vec_out,
  output logic      credit
);

  localparam int ptr_len = $clog2(`FIFO_DEPTH);

  feat_vec_t mem [`FIFO_DEPTH];
  logic [ptr_len-1:0] wr_ptr;
  logic [ptr_len-1:0] rd_ptr;
  logic [ptr_len:0]   count;

  assign vec_valid = (count != '0);
  assign vec_out   = mem[rd_ptr];  // head

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      credit <= pop;  // one credit back per pop
      if (push)
        wr_ptr <= (wr_ptr == ptr_len'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == ptr_len'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= vec_in;
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count != (ptr_len + 1)'(`FIFO_DEPTH)));

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> (count != '0));

endmodule

/* verilog/dot_channel.sv */
`timescale 1ns/1ps
`include "conv_params.svh"

module dot_channel
  import conv_pkg::*;
#(
  parameter int ch_idx = 0
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wt_wr_en,
  input  wt_wr_t                     wt_wr,
  input  logic                       run,
  input  logic [2:0]                 phase,
  input  feat_vec_t                  vec,
  output logic                       sum_valid,
  output logic signed [`ACC_LEN-1:0] sum
);

  feat_word_t wmem [`PHASES * `READS_PER_VEC];  // indexed by {phase, beat}
  feat_word_t [`READS_PER_VEC-1:0] words_r;
  logic [2:0] phase_r;
  logic [1:0] beat;
  logic       active;
  logic signed [`ACC_LEN-1:0] partial;
  logic signed [`ACC_LEN-1:0] term;
  feat_word_t cur_f;
  feat_word_t cur_w;

  function automatic logic signed [`ACC_LEN-1:0] dot9(feat_word_t f, feat_word_t w);
    logic signed [`ACC_LEN-1:0] s;
    s = '0;
    for (int i = 0; i < `READ_WORDS; i++) begin
      s = s + $signed(f.w[i]) * $signed(w.w[i]);
    end
    return s;
  endfunction

  // beat 0 runs straight off the popped head
  always_comb begin
    if (active) begin
      cur_f = words_r[beat];
      cur_w = wmem[{phase_r, beat}];
    end else begin
      cur_f = vec.words[0];
      cur_w = wmem[{phase, 2'd0}];
    end
    term = dot9(cur_f, cur_w);
  end

  assign sum = partial;  // complete while sum_valid

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active    <= 1'b0;
      beat      <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= 1'b0;
      if (active) begin
        beat <= beat + 2'd1;
        if (beat == 2'(`READS_PER_VEC - 1)) begin
          active    <= 1'b0;
          sum_valid <= 1'b1;
        end
      end else if (run) begin
        active <= 1'b1;
        beat   <= 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active) begin
      partial <= partial + term;
    end else if (run) begin
      words_r <= vec.words;
      phase_r <= phase;
      partial <= term;
    end
  end

  always_ff @(posedge clk) begin
    if (wt_wr_en && (int'(wt_wr.channel) == ch_idx))
      wmem[{wt_wr.phase, wt_wr.beat}] <= wt_wr.data;
  end

endmodule

/* verilog/dot_array.sv */
`timescale 1ns/1ps
`include "conv_params.svh"

module dot_array
  import conv_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        vec_valid,
  input  feat_vec_t   vec_out,
  output logic        pop,
  input  logic        wt_wr_en,
  input  wt_wr_t      wt_wr,
  output logic        res_valid,
  output result_row_t res_row,
  input  logic        res_ready,
  output logic        row_done
);

  logic [`CHANNELS-1:0] sum_valid;
  logic signed [`ACC_LEN-1:0] sum [`CHANNELS];
  logic signed [`ACC_LEN-1:0] acc [`CHANNELS];
  logic signed [`ACC_LEN-1:0] row_sum [`CHANNELS];
  logic       mac_run;    // channels in beats 1..3
  logic [1:0] mac_beat;
  logic [2:0] mac_phase;  // tags of the vector in the MAC
  logic [3:0] mac_row;
  logic       last_phase;

  // one vector per four cycles and none while a row waits at the output
  assign pop = vec_valid && !mac_run && !(res_valid && !res_ready);
  assign row_done = res_valid && res_ready;
  assign last_phase = (mac_phase == 3'(`PHASES - 1));

  for (genvar c = 0; c < `CHANNELS; c++) begin : g_ch
    dot_channel #(
      .ch_idx(c)
    ) u_ch (
      .clk      (clk),
      .rst_n    (rst_n),
      .wt_wr_en (wt_wr_en),
      .wt_wr    (wt_wr),
      .run      (pop),
      .phase    (vec_out.phase),
      .vec      (vec_out),
      .sum_valid(sum_valid[c]),
      .sum      (sum[c])
    );
  end

  // phase 0 starts a fresh row
  always_comb begin
    for (int c = 0; c < `CHANNELS; c++) begin
      row_sum[c] = (mac_phase == 3'd0) ? sum[c] : acc[c] + sum[c];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mac_run   <= 1'b0;
      mac_beat  <= '0;
      res_valid <= 1'b0;
    end else begin
      if (pop) begin
        mac_run  <= 1'b1;
        mac_beat <= 2'd1;
      end else if (mac_run) begin
        mac_beat <= mac_beat + 2'd1;
        if (mac_beat == 2'(`READS_PER_VEC - 1))
          mac_run <= 1'b0;
      end
      if (row_done)
        res_valid <= 1'b0;
      if (sum_valid[0] && last_phase)
        res_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      mac_phase <= vec_out.phase;
      mac_row   <= vec_out.row;
    end
    if (sum_valid[0]) begin
      for (int c = 0; c < `CHANNELS; c++) begin
        acc[c] <= row_sum[c];
      end
      if (last_phase) begin
        res_row.row <= mac_row;
        for (int c = 0; c < `CHANNELS; c++) begin
          res_row.acc[c] <= row_sum[c];
        end
      end
    end
  end

  // every channel finishes in the cycle after the array's last beat
  a_sum_valid_agree: assert property (@(posedge clk) disable iff (!rst_n)
    sum_valid == {`CHANNELS{$past(mac_run) && !mac_run}});

endmodule

/* verilog/conv_dot_top.sv */
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_dot_top
  import conv_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  output logic [`ADDR_LEN-1:0] feat_addr,
  input  feat_word_t           feat_data,
  input  logic                 wt_wr_en,
  input  wt_wr_t               wt_wr,
  output logic                 busy,
  output logic                 res_valid,
  output result_row_t          res_row,
  input  logic                 res_ready
);

  logic      push;
  feat_vec_t vec_in;
  logic      credit;
  logic      vec_valid;
  feat_vec_t vec_out;
  logic      pop;
  logic      row_done;

  feature_fetch u_fetch (
    .clk, .rst_n, .start, .feat_addr, .feat_data,
    .push, .vec_in, .credit, .busy, .row_done
  );

  vector_fifo u_fifo (
    .clk, .rst_n, .push, .vec_in, .pop, .vec_valid, .vec_out, .credit
  );

  dot_array u_array (
    .clk, .rst_n, .vec_valid, .vec_out, .pop, .wt_wr_en, .wt_wr,
    .res_valid, .res_row, .res_ready, .row_done
  );

endmodule

/* verif/conv_dot_tb.sv */
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_dot_tb
  import conv_pkg::*;
();

  typedef logic [`ACC_LEN-1:0] acc_t;
  typedef logic [`DATA_LEN-1:0] data_t;

  typedef struct packed {
    logic [1:0] stall_mode;  // 0 always ready, 1 every other cycle, 2 long stalls
    logic       restart;     // second start pulse while busy
    logic [7:0] exp_rows;
  } run_entry_t;

  localparam int num_runs = 4;
  localparam int mem_words = 1 << `ADDR_LEN;

  run_entry_t run_table [num_runs] = '{
    '{2'd0, 1'b0, 8'(`ROWS)},
    '{2'd1, 1'b1, 8'(`ROWS)},
    '{2'd2, 1'b0, 8'(`ROWS)},
    '{2'd0, 1'b1, 8'(`ROWS)}
  };

  logic                 clk;
  logic                 rst_n;
  logic                 start;
  logic [`ADDR_LEN-1:0] feat_addr;
  feat_word_t           feat_data = '0;
  logic                 wt_wr_en;
  wt_wr_t               wt_wr;
  logic                 busy;
  logic                 res_valid;
  result_row_t          res_row;
  logic                 res_ready = 1'b0;

  feat_word_t  fmem [mem_words];
  feat_word_t  wmodel [`CHANNELS][`PHASES][`READS_PER_VEC];
  result_row_t exp_rows [`ROWS];
  result_row_t prev_row;

  logic [1:0] stall_mode = 2'd0;
  int ready_cyc = 0;
  int rows_seen = 0;
  int rows_expected = 0;
  int rows_checked = 0;
  int mismatch_cnt = 0;
  int fail_cnt = 0;
  bit in_run = 1'b0;
  bit timed_out = 1'b0;
  bit prev_stalled = 1'b0;

  conv_dot_top u_dut (
    .clk, .rst_n, .start, .feat_addr, .feat_data, .wt_wr_en, .wt_wr,
    .busy, .res_valid, .res_row, .res_ready
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    feat_data <= fmem[feat_addr];  // data one cycle after the address
  end

  always @(posedge clk) begin
    ready_cyc <= ready_cyc + 1;
    case (stall_mode)
      2'd0:    res_ready <= 1'b1;
      2'd1:    res_ready <= ready_cyc[0];
      default: res_ready <= (ready_cyc % 24) >= 19;  // 19 closed, 5 open
    endcase
  end

  task automatic check_row(input string name, input result_row_t got, input result_row_t exp);
    if (got.row !== exp.row) begin
      mismatch_cnt++;
      $display("Mismatch at %0t: %s.row got %0d expected %0d", $time, name, got.row, exp.row);
    end
    for (int c = 0; c < `CHANNELS; c++) begin
      if (got.acc[c] !== exp.acc[c]) begin
        mismatch_cnt++;
        $display("Mismatch at %0t: %s.acc[%0d] got %0d expected %0d", $time, name, c,
                 $signed(got.acc[c]), $signed(exp.acc[c]));
      end
    end
  endtask

  task automatic check_busy(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %0t: %s got %0b expected %0b", $time, name, got, exp);
    end
  endtask

  // row r uses addresses r*32 + phase*4 + beat
  function automatic result_row_t expected_row(input int r);
    result_row_t er;
    feat_word_t f;
    int s;
    er.row = r[3:0];
    for (int c = 0; c < `CHANNELS; c++) begin
      s = 0;
      for (int p = 0; p < `PHASES; p++) begin
        for (int b = 0; b < `READS_PER_VEC; b++) begin
          f = fmem[r * 32 + p * 4 + b];
          for (int i = 0; i < `READ_WORDS; i++) begin
            s += int'($signed(f.w[i])) * int'($signed(wmodel[c][p][b].w[i]));
          end
        end
      end
      er.acc[c] = acc_t'(s);
    end
    return er;
  endfunction

  task automatic load_weights();
    wt_wr_t wr;
    for (int c = 0; c < `CHANNELS; c++) begin
      for (int p = 0; p < `PHASES; p++) begin
        for (int b = 0; b < `READS_PER_VEC; b++) begin
          wr.channel = c[$clog2(`CHANNELS)-1:0];
          wr.phase = p[2:0];
          wr.beat = b[1:0];
          for (int i = 0; i < `READ_WORDS; i++) begin
            wr.data.w[i] = data_t'($urandom);
          end
          wmodel[c][p][b] = wr.data;
          @(posedge clk);
          wt_wr_en <= 1'b1;
          wt_wr    <= wr;
        end
      end
    end
    @(posedge clk);
    wt_wr_en <= 1'b0;
  endtask

  task automatic wait_rows(input int target, input int limit, input string what);
    int cnt;
    cnt = 0;
    while (rows_seen < target && cnt < limit) begin
      @(posedge clk);
      cnt++;
    end
    if (rows_seen < target) begin
      fail_cnt++;
      timed_out = 1'b1;
      $display("Error at %0t: no %s within %0d cycles", $time, what, limit);
    end
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic run_entry(input run_entry_t e);
    load_weights();
    for (int r = 0; r < `ROWS; r++) begin
      exp_rows[r] = expected_row(r);
    end
    rows_seen = 0;
    rows_expected = int'(e.exp_rows);
    @(negedge clk);
    stall_mode = e.stall_mode;
    check_busy("busy", busy, 1'b0);
    pulse_start();
    @(negedge clk);
    check_busy("busy", busy, 1'b1);
    in_run = 1'b1;
    if (e.restart) begin
      wait_rows(3, 2000, "third row");
      if (timed_out)
        return;
      pulse_start();  // ignored while busy
    end
    wait_rows(int'(e.exp_rows), 4000, "last row");
    in_run = 1'b0;
    if (timed_out)
      return;
    @(negedge clk);
    check_busy("busy", busy, 1'b0);
    check_busy("res_valid", res_valid, 1'b0);
    repeat (20) @(posedge clk);  // watch for stray rows
  endtask

  // handshake monitor, sampled away from the clock edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (prev_stalled) begin
        if (!res_valid) begin
          fail_cnt++;
          $display("Error at %0t: res_valid dropped before the row was accepted", $time);
        end else begin
          check_row("res_row", res_row, prev_row);
        end
      end
      if (in_run)
        check_busy("busy", busy, 1'b1);
      if (res_valid && res_ready) begin
        if (rows_seen >= rows_expected) begin
          fail_cnt++;
          $display("Error at %0t: extra row %0d accepted after the run", $time, res_row.row);
        end else begin
          check_row("res_row", res_row, exp_rows[rows_seen]);
          rows_checked++;
        end
        rows_seen++;
      end
      prev_stalled = res_valid && !res_ready;
      prev_row = res_row;
    end
  end

  initial begin
    void'($urandom(32'hc20890b9));
    rst_n    <= 1'b0;
    start    <= 1'b0;
    wt_wr_en <= 1'b0;
    wt_wr    <= '0;
    for (int a = 0; a < mem_words; a++) begin
      for (int i = 0; i < `READ_WORDS; i++) begin
        fmem[a].w[i] = data_t'($urandom);
      end
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_busy("busy", busy, 1'b0);
    check_busy("res_valid", res_valid, 1'b0);
    for (int i = 0; i < num_runs; i++) begin
      if (!timed_out)
        run_entry(run_table[i]);
    end
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $display("errors: %0d mismatches, %0d other failures, %0d rows checked",
             mismatch_cnt, fail_cnt, rows_checked);
    $finish;
  end

endmodule

/* vlog.f */
+incdir+verilog
verilog/conv_pkg.sv
verilog/feature_fetch.sv
verilog/vector_fifo.sv
verilog/dot_channel.sv
verilog/dot_array.sv
verilog/conv_dot_top.sv
verif/conv_dot_tb.sv

/* Makefile */
TOP := conv_dot_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
	  echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
	  echo "FAIL: no result line in $(LOG)"; exit 1; \
	else \
	  echo "PASS"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
